//--- common/bootPkg.sv
package bootPkg;

    // one received serial byte
    localparam int byteWidth = 8;

    // one instruction word, four bytes
    localparam int wordWidth = 32;

    // byte address of the fetch port
    localparam int addrWidth = 8;

    // loader progress through the boot stream
    // Lane3 holds the first byte of each word, which lands in the top lane
    typedef enum logic [2:0] {
        RecvSize,
        Lane3,
        Lane2,
        Lane1,
        Lane0,
        Running
    } loadState;

endpackage

//--- source/uartRx.sv
`timescale 1ns/1ns

module uartRx #(
    parameter int clksPerBit = 234
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          rxd,
    output logic                          byteValid,
    output logic [bootPkg::byteWidth-1:0] byteData
);

    localparam int cntWidth = $clog2(clksPerBit);
    localparam logic [cntWidth-1:0] halfBitLast = cntWidth'(clksPerBit / 2 - 1);
    localparam logic [cntWidth-1:0] fullBitLast = cntWidth'(clksPerBit - 1);

    typedef enum logic [1:0] {
        RxIdle,
        RxStart,
        RxData,
        RxStop
    } rxStateT;

    rxStateT rxState;

    logic                          rxdMeta;
    logic                          rxdSync;
    logic                          rxdPrev;
    logic                          startEdge;
    logic [cntWidth-1:0]           bitTimer;
    logic [2:0]                    bitCount;
    logic [bootPkg::byteWidth-1:0] shiftReg;

    // line idles high, so the synchroniser resets high too
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxdMeta <= 1'b1;
            rxdSync <= 1'b1;
            rxdPrev <= 1'b1;
        end else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
            rxdPrev <= rxdSync;
        end
    end

    assign startEdge = rxdPrev & ~rxdSync;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rxState   <= RxIdle;
            bitTimer  <= '0;
            bitCount  <= '0;
            byteValid <= 1'b0;
        end else begin
            byteValid <= 1'b0;
            case (rxState)
                RxIdle: begin
                    bitTimer <= '0;
                    if (startEdge) begin
                        rxState <= RxStart;
                    end
                end
                RxStart: begin
                    // check the start bit at its centre
                    if (bitTimer == halfBitLast) begin
                        bitTimer <= '0;
                        bitCount <= '0;
                        rxState  <= rxdSync ? RxIdle : RxData;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                RxData: begin
                    if (bitTimer == fullBitLast) begin
                        bitTimer <= '0;
                        bitCount <= bitCount + 1'b1;
                        if (bitCount == 3'd7) begin
                            rxState <= RxStop;
                        end
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                RxStop: begin
                    // a low stop bit is a framing error, byte is dropped
                    if (bitTimer == fullBitLast) begin
                        byteValid <= rxdSync;
                        rxState   <= RxIdle;
                    end else begin
                        bitTimer <= bitTimer + 1'b1;
                    end
                end
                default: rxState <= RxIdle;
            endcase
        end
    end

    // lsb first, so new bits enter at the top
    always_ff @(posedge clk) begin
        if (rxState == RxData && bitTimer == fullBitLast) begin
            shiftReg <= {rxdSync, shiftReg[bootPkg::byteWidth-1:1]};
        end
    end

    assign byteData = shiftReg;

endmodule

//--- source/progLoader.sv
`timescale 1ns/1ns

module progLoader #(
    parameter int memWords = 64,
    localparam int idxWidth = $clog2(memWords + 1)
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          byteValid,
    input  logic [bootPkg::byteWidth-1:0] byteData,
    output logic                          wrEn,
    output logic [idxWidth-1:0]           wrIndex,
    output logic [bootPkg::wordWidth-1:0] wrData,
    output logic                          cpuEnable
);

    localparam logic [bootPkg::byteWidth-1:0] sizeLimit = bootPkg::byteWidth'(memWords);

    bootPkg::loadState state;

    logic [idxWidth-1:0]             wordIdx;
    logic [idxWidth-1:0]             nextIdx;
    logic [idxWidth-1:0]             sizeReg;
    logic [idxWidth-1:0]             clipSize;
    logic [3*bootPkg::byteWidth-1:0] holdReg;

    // lengths past the end of memory are clipped
    assign clipSize = (byteData > sizeLimit) ? idxWidth'(memWords) : idxWidth'(byteData);
    assign nextIdx  = wordIdx + 1'b1;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= bootPkg::RecvSize;
            wrEn      <= 1'b0;
            cpuEnable <= 1'b0;
            wordIdx   <= '0;
            sizeReg   <= '0;
        end else begin
            wrEn <= 1'b0;
            if (byteValid) begin
                case (state)
                    bootPkg::RecvSize: begin
                        if (byteData == '0) begin
                            // empty program, start the cpu straight away
                            state     <= bootPkg::Running;
                            cpuEnable <= 1'b1;
                        end else begin
                            sizeReg <= clipSize;
                            wordIdx <= '0;
                            state   <= bootPkg::Lane3;
                        end
                    end
                    bootPkg::Lane3: state <= bootPkg::Lane2;
                    bootPkg::Lane2: state <= bootPkg::Lane1;
                    bootPkg::Lane1: state <= bootPkg::Lane0;
                    bootPkg::Lane0: begin
                        wrEn    <= 1'b1;
                        wordIdx <= nextIdx;
                        if (nextIdx == sizeReg) begin
                            state     <= bootPkg::Running;
                            cpuEnable <= 1'b1;
                        end else begin
                            state <= bootPkg::Lane3;
                        end
                    end
                    // Running ignores every later byte
                    default: state <= state;
                endcase
            end
        end
    end

    // upper three bytes wait here until lane 0 arrives
    always_ff @(posedge clk) begin
        if (byteValid) begin
            case (state)
                bootPkg::Lane3: holdReg[23:16] <= byteData;
                bootPkg::Lane2: holdReg[15:8]  <= byteData;
                bootPkg::Lane1: holdReg[7:0]   <= byteData;
                bootPkg::Lane0: begin
                    wrData  <= {holdReg, byteData};
                    wrIndex <= wordIdx;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/instrMem.sv
`timescale 1ns/1ns

module instrMem #(
    parameter int memWords = 64,
    localparam int idxWidth = $clog2(memWords + 1)
) (
    input  logic                          clk,
    input  logic                          wrEn,
    input  logic [idxWidth-1:0]           wrIndex,
    input  logic [bootPkg::wordWidth-1:0] wrData,
    input  logic [bootPkg::addrWidth-1:0] fetchAddr,
    output logic [bootPkg::wordWidth-1:0] fetchData
);

    localparam int wordAddrWidth = $clog2(memWords);
    localparam logic [idxWidth-1:0] depth = idxWidth'(memWords);

    logic [bootPkg::wordWidth-1:0] mem [memWords];

    logic [wordAddrWidth-1:0]      loIdx;
    logic [wordAddrWidth-1:0]      hiIdx;
    logic [bootPkg::wordWidth-1:0] loWord;
    logic [bootPkg::wordWidth-1:0] hiWord;

    always_ff @(posedge clk) begin
        if (wrEn && wrIndex < depth) begin
            mem[wrIndex[wordAddrWidth-1:0]] <= wrData;
        end
    end

    // address taken modulo the memory size, next word wraps to 0
    assign loIdx  = fetchAddr[wordAddrWidth+1:2];
    assign hiIdx  = loIdx + 1'b1;
    assign loWord = mem[loIdx];
    assign hiWord = mem[hiIdx];

    // byte a ends up in bits 7:0
    always_comb begin
        case (fetchAddr[1:0])
            2'd0:    fetchData = loWord;
            2'd1:    fetchData = {hiWord[7:0], loWord[31:8]};
            2'd2:    fetchData = {hiWord[15:0], loWord[31:16]};
            default: fetchData = {hiWord[23:0], loWord[31:24]};
        endcase
    end

endmodule

//--- source/bootTop.sv
`timescale 1ns/1ns

module bootTop #(
    parameter int clksPerBit = 234,
    parameter int memWords   = 64
) (
    input  logic                          clk,
    input  logic                          rstN,
    input  logic                          uartRxd,
    input  logic [bootPkg::addrWidth-1:0] fetchAddr,
    output logic [bootPkg::wordWidth-1:0] fetchData,
    output logic                          cpuEnable,
    output logic [5:0]                    led
);

    localparam int idxWidth = $clog2(memWords + 1);

    logic                          byteValid;
    logic [bootPkg::byteWidth-1:0] byteData;
    logic                          wrEn;
    logic [idxWidth-1:0]           wrIndex;
    logic [bootPkg::wordWidth-1:0] wrData;

    uartRx #(
        .clksPerBit(clksPerBit)
    ) u_uartRx (
        .clk      (clk),
        .rstN     (rstN),
        .rxd      (uartRxd),
        .byteValid(byteValid),
        .byteData (byteData)
    );

    progLoader #(
        .memWords(memWords)
    ) u_progLoader (
        .clk      (clk),
        .rstN     (rstN),
        .byteValid(byteValid),
        .byteData (byteData),
        .wrEn     (wrEn),
        .wrIndex  (wrIndex),
        .wrData   (wrData),
        .cpuEnable(cpuEnable)
    );

    instrMem #(
        .memWords(memWords)
    ) u_instrMem (
        .clk      (clk),
        .wrEn     (wrEn),
        .wrIndex  (wrIndex),
        .wrData   (wrData),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData)
    );

    // leds are active low
    assign led = ~fetchData[5:0];

endmodule

//--- testbench/bootTb.sv
`timescale 1ns/1ns

module bootTb;

    localparam int bitClks      = 16;
    localparam int depthWords   = 16;
    localparam int memBytes     = 4 * depthWords;
    localparam int byteIdxWidth = $clog2(memBytes);

    // frames per phase including the bad frame and the late frames
    localparam int phase1Bytes = 1 + 20 + 1 + 5;
    localparam int phase2Bytes = 1 + 64 + 5;
    localparam int phase3Bytes = 1;
    localparam int totalBytes  = phase1Bytes + phase2Bytes + phase3Bytes;
    localparam int timeoutNs   = 2 * (totalBytes * 10 * bitClks * 20) + 10000;

    logic                          clk;
    logic                          rstN;
    logic                          uartRxd;
    logic [bootPkg::addrWidth-1:0] fetchAddr;
    logic [bootPkg::wordWidth-1:0] fetchData;
    logic                          cpuEnable;
    logic [5:0]                    led;

    logic [bootPkg::byteWidth-1:0] model [memBytes];
    logic [31:0]                   rngState;
    logic                          enableAllowed;
    int                            errorCount;
    int                            assertFails;
    int                            checkCount;
    bootPkg::loadState             loaderState;

    bootTop #(
        .clksPerBit(bitClks),
        .memWords  (depthWords)
    ) u_bootTop (
        .clk      (clk),
        .rstN     (rstN),
        .uartRxd  (uartRxd),
        .fetchAddr(fetchAddr),
        .fetchData(fetchData),
        .cpuEnable(cpuEnable),
        .led      (led)
    );

    assign loaderState = u_bootTop.u_progLoader.state;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // cpuEnable stays high until the next reset
    assert property (@(posedge clk) disable iff (!rstN) $past(cpuEnable) |-> cpuEnable)
        else begin
            assertFails++;
            $display("Mismatch at %0t: cpuEnable fell without a reset", $time);
        end

    assert property (@(posedge clk) disable iff (!rstN) cpuEnable |-> enableAllowed)
        else begin
            assertFails++;
            $display("Mismatch at %0t: cpuEnable high too early, loader in %s",
                     $time, loaderState.name());
        end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // model bytes a to a+3 with byte a lowest
    function automatic logic [bootPkg::wordWidth-1:0] expectedWord(input int a);
        logic [bootPkg::wordWidth-1:0] w;
        logic [byteIdxWidth-1:0]       idx;
        w = '0;
        for (int j = 0; j < 4; j++) begin
            idx = byteIdxWidth'(a + j);
            w = {model[idx], w[31:8]};
        end
        return w;
    endfunction

    task automatic driveBit(input logic b);
        uartRxd = b;
        repeat (bitClks) @(posedge clk);
        #2;
    endtask

    task automatic sendFrame(input logic [bootPkg::byteWidth-1:0] value, input logic badStop);
        logic [bootPkg::byteWidth-1:0] shifter;
        shifter = value;
        driveBit(1'b0);
        for (int i = 0; i < bootPkg::byteWidth; i++) begin
            driveBit(shifter[0]);
            shifter = shifter >> 1;
        end
        driveBit(!badStop);
        // line back high so the next start bit gives an edge
        if (badStop) begin
            driveBit(1'b1);
        end
    endtask

    task automatic expectLow();
        assert (!cpuEnable) else begin
            errorCount++;
            $display("Mismatch at %0t: cpuEnable high before the last byte, loader in %s",
                     $time, loaderState.name());
        end
    endtask

    task automatic waitEnable();
        int n;
        n = 0;
        while (!cpuEnable && n < 20 * bitClks) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (!cpuEnable) begin
            errorCount++;
            $display("cpuEnable never rose after the load, loader stuck in %s",
                     loaderState.name());
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        enableAllowed = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
    endtask

    // badAt puts a frame with a low stop bit before that data byte
    task automatic loadProgram(input logic [bootPkg::byteWidth-1:0] lenByte, input int words,
                               input int badAt);
        logic [bootPkg::byteWidth-1:0] value;
        logic [byteIdxWidth-1:0]       idx;
        int                            last;
        last = 4 * words - 1;
        if (words == 0) begin
            enableAllowed = 1'b1;
        end
        sendFrame(lenByte, 1'b0);
        for (int j = 0; j <= last; j++) begin
            expectLow();
            if (j == badAt) begin
                rngState = xorshift(rngState);
                sendFrame(rngState[7:0], 1'b1);
                expectLow();
            end
            rngState = xorshift(rngState);
            value = rngState[7:0];
            // first byte of a word lands in lane 3
            idx = byteIdxWidth'(4 * (j / 4) + 3 - (j % 4));
            model[idx] = value;
            if (j == last) begin
                enableAllowed = 1'b1;
            end
            sendFrame(value, 1'b0);
        end
        waitEnable();
    endtask

    task automatic sendExtra(input int count);
        for (int i = 0; i < count; i++) begin
            rngState = xorshift(rngState);
            sendFrame(rngState[7:0], 1'b0);
        end
    endtask

    task automatic checkFetch(input int a);
        logic [bootPkg::wordWidth-1:0] exp;
        fetchAddr = bootPkg::addrWidth'(a);
        exp = expectedWord(a);
        @(negedge clk);
        checkCount++;
        assert (fetchData === exp) else begin
            errorCount++;
            $display("Mismatch at %0t: fetch at 0x%02h gave %08h, expected %08h",
                     $time, a, fetchData, exp);
        end
        assert (led === ~exp[5:0]) else begin
            errorCount++;
            $display("Mismatch at %0t: led %b at 0x%02h, expected %b",
                     $time, led, a, ~exp[5:0]);
        end
        @(posedge clk);
        #2;
    endtask

    task automatic checkRange(input int first, input int last, input int step);
        for (int a = first; a <= last; a += step) begin
            checkFetch(a);
        end
    endtask

    initial begin
        rstN          = 1'b0;
        uartRxd       = 1'b1;
        fetchAddr     = '0;
        enableAllowed = 1'b0;
        rngState      = 32'h3fe;
        errorCount    = 0;
        assertFails   = 0;
        checkCount    = 0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;

        // five words with a framing error inside word 2
        loadProgram(8'd5, 5, 10);
        checkRange(0, 16, 4);
        checkRange(1, 15, 1);
        sendExtra(5);
        checkRange(0, 16, 4);
        checkRange(1, 15, 1);

        // oversized length clips to a full load so the last word wraps to word 0
        applyReset();
        loadProgram(8'd20, 16, -1);
        checkRange(0, 63, 1);
        checkFetch(125);
        checkFetch(255);
        sendExtra(5);
        checkRange(0, 63, 1);

        // empty program
        applyReset();
        loadProgram(8'd0, 0, -1);
        checkFetch(0);
        checkFetch(62);

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(timeoutNs);
        $display("timeout: the run did not finish within %0d ns", timeoutNs);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        $display("tests failed");
        $finish;
    end

endmodule

//--- verilog.f
common/bootPkg.sv
source/uartRx.sv
source/progLoader.sv
source/instrMem.sv
source/bootTop.sv
testbench/bootTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing --assert --timescale 1ns/1ns
TOP       = bootTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
